/* common/ghrd_consts.svh */
/*
 * fabric constants for the HPS reset request and LED loan I/O blocks
 * pulse lengths in h2f_user0_clock cycles, loan I/O bit positions
 */
`ifndef GHRD_CONSTS_SVH
`define GHRD_CONSTS_SVH

//########################################
// reset request pulse stretch
//########################################
`define COLD_PULSE_LEN   6    // cold reset, cycles low
`define WARM_PULSE_LEN   2    // warm reset
`define DEBUG_PULSE_LEN  32   // debug reset, longest channel
`define PULSE_CNT_BITS   6    // holds DEBUG_PULSE_LEN - 1

//########################################
// LED loan I/O
//########################################
`define LOAN_IO_BITS     67   // full HPS loan I/O vector
`define LED_COUNT        4    // LED PIO bits

// loan positions of the user LEDs D5..D8
`define LED0_LOAN_POS    14
`define LED1_LOAN_POS    22
`define LED2_LOAN_POS    25
`define LED3_LOAN_POS    32

// heartbeat, top bit drives the RF1 LED
`define HEARTBEAT_BITS   25

`endif

/* common/hps_reset_pkg.sv */
/*
 * types for the HPS reset request channels
 * one bit per channel, plus the pulse stretcher FSM
 */
`include "ghrd_consts.svh"

package hps_reset_pkg;

	// one bit per reset channel
	// used for req, ack and the active-low requests to the HPS
	typedef struct packed {
		logic cold;   // cold reset
		logic warm;   // warm reset
		logic debug;  // debug reset
	} reset_chan_t;

	// pulse stretch down-counter
	typedef logic [`PULSE_CNT_BITS-1:0] pulse_cnt_t;

	// per channel FSM
	typedef enum logic [1:0] {
		st_idle,      // waiting for req edge
		st_pulse,     // reset_n held low
		st_release    // ack high until req drops
	} pulse_state_t;

endpackage

/* common/board_io_pkg.sv */
/*
 * types for the LED PIO, HPS loan I/O vectors and loan bit positions
 */
`include "ghrd_consts.svh"

package board_io_pkg;

	// LED PIO value, bit set = LED on
	typedef logic [`LED_COUNT-1:0] led_t;

	// one loan I/O vector, out or oe
	typedef logic [`LOAN_IO_BITS-1:0] loan_io_t;

	// bit index into a loan I/O vector
	typedef logic [$clog2(`LOAN_IO_BITS)-1:0] loan_pos_t;

	// what the fabric hands to the HPS loan I/O port
	typedef struct packed {
		loan_io_t loan_out;  // pin levels
		loan_io_t loan_oe;   // output enables
	} board_leds_t;

endpackage

/* design/hps_reset/hps_reset_pulse.sv */
/*
 * single HPS reset request channel
 * rising req starts an active-low pulse of pulse_len cycles,
 * then ack is held until req drops (four-phase handshake)
 */
`timescale 1ns/1ps
`include "ghrd_consts.svh"

module hps_reset_pulse
	import hps_reset_pkg::*;
#(
	parameter int pulse_len = `COLD_PULSE_LEN  // cycles of reset_n low
) (
	input  logic h2f_user0_clock,
	input  logic hps_fpga_reset_n,   // active high, sync
	input  logic req,                // from requester
	output logic ack,                // pulse done
	output logic reset_n             // to HPS reset request
);

	//########################################
	// edge capture
	//########################################
	logic         req_d;     // last sampled req
	logic         req_rise;
	pulse_state_t state;
	pulse_cnt_t   cnt;       // cycles left in pulse
	logic         cnt_done;

	assign req_rise = req & ~req_d;
	assign cnt_done = (cnt == '0);

	//########################################
	// pulse FSM
	//########################################
	always_ff @(posedge h2f_user0_clock) begin
		if (hps_fpga_reset_n) begin
			state   <= st_idle;
			req_d   <= 1'b0;
			reset_n <= 1'b1;  // no request out of reset
			ack     <= 1'b0;
		end else begin
			req_d <= req;
			case (state)
				st_idle: begin
					// new request, drop reset_n next cycle
					if (req_rise) begin
						state   <= st_pulse;
						reset_n <= 1'b0;
					end
				end
				st_pulse: begin
					// req is not looked at here, toggles ignored
					if (cnt_done) begin
						state   <= st_release;
						reset_n <= 1'b1;
						ack     <= 1'b1;  // same edge reset_n returns high
					end
				end
				st_release: begin
					if (!req) begin
						state <= st_idle;
						ack   <= 1'b0;
					end
				end
				default: begin
					state   <= st_idle;
					reset_n <= 1'b1;
					ack     <= 1'b0;
				end
			endcase
		end
	end

	//########################################
	// stretch counter
	//########################################
	// preloaded while idle, so the first pulse cycle already counts
	always_ff @(posedge h2f_user0_clock) begin
		if (state == st_idle)
			cnt <= pulse_cnt_t'(pulse_len - 1);
		else if (state == st_pulse && !cnt_done)
			cnt <= cnt - pulse_cnt_t'(1);  // count down to zero
	end

endmodule

/* design/hps_reset/hps_reset_ctrl.sv */
/*
 * HPS reset request control, cold / warm / debug channels
 * each channel stretched to its own length, gathered into structs
 */
`timescale 1ns/1ps
`include "ghrd_consts.svh"

module hps_reset_ctrl
	import hps_reset_pkg::*;
(
	input  logic        h2f_user0_clock,
	input  logic        hps_fpga_reset_n,
	input  reset_chan_t reset_req,    // per channel req
	output reset_chan_t reset_ack,    // per channel ack
	output reset_chan_t f2h_reset_n   // active-low to HPS
);

	// per channel results
	logic cold_ack, warm_ack, debug_ack;
	logic cold_rst_n, warm_rst_n, debug_rst_n;

	// cold reset, 6 cycles
	hps_reset_pulse #(.pulse_len(`COLD_PULSE_LEN)) cold_pulse_i (
		.h2f_user0_clock  (h2f_user0_clock),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.req              (reset_req.cold),
		.ack              (cold_ack),
		.reset_n          (cold_rst_n)
	);

	// warm reset, 2 cycles
	hps_reset_pulse #(.pulse_len(`WARM_PULSE_LEN)) warm_pulse_i (
		.h2f_user0_clock  (h2f_user0_clock),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.req              (reset_req.warm),
		.ack              (warm_ack),
		.reset_n          (warm_rst_n)
	);

	// debug reset, 32 cycles
	hps_reset_pulse #(.pulse_len(`DEBUG_PULSE_LEN)) debug_pulse_i (
		.h2f_user0_clock  (h2f_user0_clock),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.req              (reset_req.debug),
		.ack              (debug_ack),
		.reset_n          (debug_rst_n)
	);

	// back into channel structs
	assign reset_ack   = '{cold: cold_ack, warm: warm_ack, debug: debug_ack};
	assign f2h_reset_n = '{cold: cold_rst_n, warm: warm_rst_n, debug: debug_rst_n};

endmodule

/* design/board_led_ctrl.sv */
/*
 * LED PIO onto the HPS loan I/O and the RF1 heartbeat
 * LEDs are active low on the board, so each bit goes out inverted
 */
`timescale 1ns/1ps
`include "ghrd_consts.svh"

module board_led_ctrl
	import board_io_pkg::*;
#(
	parameter int heartbeat_bits = `HEARTBEAT_BITS  // rf1 period 2^heartbeat_bits
) (
	input  logic        h2f_user0_clock,
	input  logic        hps_fpga_reset_n,  // active high, sync
	input  led_t        led_pio,           // 1 = LED on
	output board_leds_t leds,              // loan out / oe, registered
	output logic        rf1_led            // heartbeat blink
);

	// LED n sits on loan bit led_loan_pos[n]
	localparam loan_pos_t led_loan_pos [`LED_COUNT] = '{
		`LED0_LOAN_POS,   // D5
		`LED1_LOAN_POS,   // D6
		`LED2_LOAN_POS,   // D7
		`LED3_LOAN_POS    // D8
	};

	board_leds_t               leds_next;
	logic [heartbeat_bits-1:0] hb_cnt;

	//########################################
	// loan I/O mapping
	//########################################
	always_comb begin
		leds_next = '0;  // unused loan bits stay off, not driven
		for (int i = 0; i < `LED_COUNT; i++) begin
			leds_next.loan_out[led_loan_pos[i]] = ~led_pio[i];  // active-low pin
			leds_next.loan_oe[led_loan_pos[i]]  = 1'b1;
		end
	end

	always_ff @(posedge h2f_user0_clock) begin
		if (hps_fpga_reset_n)
			leds <= '0;
		else
			leds <= leds_next;
	end

	//########################################
	// heartbeat
	//########################################
	// free running, shows the fabric clock is alive
	always_ff @(posedge h2f_user0_clock) begin
		if (hps_fpga_reset_n)
			hb_cnt <= '0;
		else
			hb_cnt <= hb_cnt + 1'b1;
	end

	assign rf1_led = hb_cnt[heartbeat_bits-1];  // toggles every 2^(bits-1)

endmodule

/* design/ghrd_fabric.sv */
/*
 * fabric top level clocked by h2f_user0_clock
 * HPS reset request channels plus LED loan I/O and heartbeat
 */
`timescale 1ns/1ps
`include "ghrd_consts.svh"

module ghrd_fabric
	import hps_reset_pkg::*;
	import board_io_pkg::*;
#(
	parameter int heartbeat_bits = `HEARTBEAT_BITS
) (
	input  logic        h2f_user0_clock,   // HPS user clock 0
	input  logic        hps_fpga_reset_n,  // from HPS, active high
	// reset request handshake
	input  reset_chan_t reset_req,
	output reset_chan_t reset_ack,
	output reset_chan_t f2h_reset_n,       // to HPS reset request ports
	// LEDs
	input  led_t        led_pio,
	output board_leds_t leds,              // to HPS loan I/O
	output logic        rf1_led
);

	//########################################
	// reset requests
	//########################################
	hps_reset_ctrl hps_reset_ctrl_i (
		.h2f_user0_clock  (h2f_user0_clock),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.reset_req        (reset_req),
		.reset_ack        (reset_ack),
		.f2h_reset_n      (f2h_reset_n)
	);

	//########################################
	// LEDs and heartbeat
	//########################################
	board_led_ctrl #(
		.heartbeat_bits (heartbeat_bits)
	) board_led_ctrl_i (
		.h2f_user0_clock  (h2f_user0_clock),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.led_pio          (led_pio),
		.leds             (leds),
		.rf1_led          (rf1_led)
	);

endmodule

/* tb/tb_ghrd_tasks.svh */
/*
 * directed tests for the fabric top level
 * reset state, reset request channels, LED loan I/O, heartbeat
 */
`ifndef TB_GHRD_TASKS_SVH
`define TB_GHRD_TASKS_SVH

//########################################
// reset state
//########################################
// called while reset is still held
task automatic test_reset_state();
	check_val("f2h_reset_n", 3'b111, f2h_reset_n);  // no request to HPS
	check_val("reset_ack", 3'b000, reset_ack);
	check_val("leds.loan_out", '0, leds.loan_out);
	check_val("leds.loan_oe", '0, leds.loan_oe);
	check_val("rf1_led", 1'b0, rf1_led);            // counter cleared
endtask

//########################################
// reset request channels
//########################################
task automatic test_single_channel(input int c);
	logic [2:0] mask;
	mask = 3'b001 << c;
	watch_pulses(mask, 1'b0);
	check_val({"f2h_reset_n.", chan_name(c), " low cycles"}, chan_len(c), low_cycles[c]);
	check_val({"f2h_reset_n.", chan_name(c), " low runs"}, 1, low_runs[c]);
	// the other two stay quiet
	for (int o = 0; o < 3; o++) begin
		if (o != c)
			check_val({"f2h_reset_n.", chan_name(o), " low cycles"}, 0, low_cycles[o]);
	end
	release_req(mask);
endtask

// debug req bounced while the pulse runs, one pulse only
task automatic test_ignore_busy();
	watch_pulses(3'b001, 1'b1);
	check_val("f2h_reset_n.debug low cycles", `DEBUG_PULSE_LEN, low_cycles[0]);
	check_val("f2h_reset_n.debug low runs", 1, low_runs[0]);
	check_val("f2h_reset_n.cold low cycles", 0, low_cycles[2]);
	check_val("f2h_reset_n.warm low cycles", 0, low_cycles[1]);
	release_req(3'b001);
endtask

// all three at once, each keeps its own length
task automatic test_all_channels();
	watch_pulses(3'b111, 1'b0);
	for (int c = 0; c < 3; c++) begin
		check_val({"f2h_reset_n.", chan_name(c), " low cycles"}, chan_len(c), low_cycles[c]);
		check_val({"f2h_reset_n.", chan_name(c), " low runs"}, 1, low_runs[c]);
	end
	release_req(3'b111);
endtask

//########################################
// LED loan I/O
//########################################
task automatic test_led_mapping();
	led_t     v;
	loan_io_t exp_out;
	loan_io_t exp_oe;
	for (int i = 0; i < 20; i++) begin
		v       = led_t'($random(seed));
		led_pio = v;
		@(negedge h2f_user0_clock);  // one register stage
		exp_out = '0;
		exp_oe  = '0;
		// LEDs are active low on the pins
		exp_out[`LED0_LOAN_POS] = ~v[0];
		exp_out[`LED1_LOAN_POS] = ~v[1];
		exp_out[`LED2_LOAN_POS] = ~v[2];
		exp_out[`LED3_LOAN_POS] = ~v[3];
		exp_oe[`LED0_LOAN_POS]  = 1'b1;
		exp_oe[`LED1_LOAN_POS]  = 1'b1;
		exp_oe[`LED2_LOAN_POS]  = 1'b1;
		exp_oe[`LED3_LOAN_POS]  = 1'b1;
		check_val("leds.loan_out", exp_out, leds.loan_out);
		check_val("leds.loan_oe", exp_oe, leds.loan_oe);
	end
	led_pio = '0;
endtask

//########################################
// heartbeat
//########################################
// falling edges until rf1_led changes, gives up after 40
task automatic cycles_to_toggle(output int gap);
	logic last;
	last = rf1_led;
	gap  = 0;
	while (rf1_led == last && gap < 40) begin
		@(negedge h2f_user0_clock);
		gap++;
	end
	if (rf1_led == last) begin
		other_errors++;
		$display("ERROR: rf1_led did not toggle within 40 cycles");
	end
endtask

task automatic test_heartbeat();
	int gap;
	cycles_to_toggle(gap);  // line up with a toggle first
	for (int k = 0; k < 2; k++) begin
		cycles_to_toggle(gap);
		check_val("rf1_led toggle interval", 1 << (hb_bits - 1), gap);  // 16
	end
endtask

`endif

/* tb/tb_ghrd_fabric.sv */
/*
 * testbench for the fabric top level
 * reset request handshakes, LED loan I/O mapping and heartbeat
 */
`timescale 1ns/1ps
`include "ghrd_consts.svh"

module tb_ghrd_fabric
	import hps_reset_pkg::*;
	import board_io_pkg::*;
();

	localparam int hb_bits        = 5;     // rf1 toggles every 16 cycles
	localparam int timeout_cycles = 2000;  // tests take a few hundred cycles
	localparam int ack_limit      = 60;    // longest pulse is 32

	//########################################
	// DUT signals
	//########################################
	logic        h2f_user0_clock;
	logic        hps_fpga_reset_n;  // high = in reset
	reset_chan_t reset_req;
	reset_chan_t reset_ack;
	reset_chan_t f2h_reset_n;
	led_t        led_pio;
	board_leds_t leds;
	logic        rf1_led;

	// bookkeeping
	int check_errors = 0;  // value mismatches
	int other_errors = 0;  // missing handshakes, stuck signals
	int cycle_cnt    = 0;
	int seed;

	// per channel results of the last pulse watch, index = bit in reset_chan_t
	int low_cycles [3];
	int low_runs   [3];

	ghrd_fabric #(
		.heartbeat_bits (hb_bits)
	) dut_i (
		.h2f_user0_clock  (h2f_user0_clock),
		.hps_fpga_reset_n (hps_fpga_reset_n),
		.reset_req        (reset_req),
		.reset_ack        (reset_ack),
		.f2h_reset_n      (f2h_reset_n),
		.led_pio          (led_pio),
		.leds             (leds),
		.rf1_led          (rf1_led)
	);

	//########################################
	// clock and timeout
	//########################################
	initial begin
		h2f_user0_clock = 1'b0;
		forever #50 h2f_user0_clock = ~h2f_user0_clock;  // 100 ns period
	end

	always @(posedge h2f_user0_clock) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= timeout_cycles) begin
			$display("ERROR: timeout, run still going after %0d cycles", cycle_cnt);
			$display("TEST FAILED");
			$finish;
		end
	end

	//########################################
	// helpers
	//########################################
	task automatic check_val(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (expected !== actual) begin
			check_errors++;
			$display("CHECK FAILED at %0t: %s expected %0h got %0h",
				$time, name, expected, actual);
		end
	endtask

	// bit 2 cold, bit 1 warm, bit 0 debug
	function automatic int chan_len(input int c);
		case (c)
			2:       return `COLD_PULSE_LEN;
			1:       return `WARM_PULSE_LEN;
			default: return `DEBUG_PULSE_LEN;
		endcase
	endfunction

	function automatic string chan_name(input int c);
		case (c)
			2:       return "cold";
			1:       return "warm";
			default: return "debug";
		endcase
	endfunction

	// raises req on the masked channels and samples every falling edge
	// until all of them ack; optionally toggles debug req mid pulse
	task automatic watch_pulses(input logic [2:0] mask, input bit toggle_debug);
		logic [2:0] prev_rst;
		logic [2:0] cur_rst;
		logic [2:0] cur_ack;
		int         n;
		bit         done;
		for (int c = 0; c < 3; c++) begin
			low_cycles[c] = 0;
			low_runs[c]   = 0;
		end
		prev_rst  = 3'b111;
		n         = 0;
		done      = 1'b0;
		reset_req = reset_req | mask;  // driven on this falling edge
		while (!done) begin
			@(negedge h2f_user0_clock);
			cur_rst = f2h_reset_n;
			cur_ack = reset_ack;
			for (int c = 0; c < 3; c++) begin
				if (!cur_rst[c]) begin
					low_cycles[c]++;
					if (prev_rst[c])
						low_runs[c]++;  // new low run
				end else if (!prev_rst[c] && mask[c]) begin
					// ack must be up right as reset_n returns
					check_val({"reset_ack.", chan_name(c)}, 1'b1, cur_ack[c]);
				end
			end
			prev_rst = cur_rst;
			// low at 4, high at 6, low at 8, high at 10, all inside the pulse
			if (toggle_debug && n >= 4 && n <= 10 && (n % 2) == 0)
				reset_req.debug = ~reset_req.debug;
			n++;
			if ((cur_ack & mask) == mask) begin
				done = 1'b1;
			end else if (n > ack_limit) begin
				other_errors++;
				$display("ERROR: no ack on channel mask %b within %0d cycles", mask, ack_limit);
				done = 1'b1;
			end
		end
	endtask

	// drop req, ack has to follow one cycle later
	task automatic release_req(input logic [2:0] mask);
		logic [2:0] ack_now;
		reset_req = reset_req & ~mask;
		@(negedge h2f_user0_clock);
		ack_now = reset_ack;
		check_val("reset_ack after req drop", 3'b000, ack_now & mask);
		check_val("f2h_reset_n after handshake", 3'b111, f2h_reset_n);
		@(negedge h2f_user0_clock);
	endtask

	`include "tb_ghrd_tasks.svh"

	//########################################
	// test sequence
	//########################################
	initial begin
		seed             = 32'ha521;
		hps_fpga_reset_n = 1'b1;  // reset held from time zero
		reset_req        = '0;
		led_pio          = '0;
		repeat (8) @(negedge h2f_user0_clock);
		test_reset_state();
		hps_fpga_reset_n = 1'b0;
		repeat (2) @(negedge h2f_user0_clock);

		test_single_channel(2);  // cold
		test_single_channel(1);  // warm
		test_single_channel(0);  // debug
		test_ignore_busy();
		test_all_channels();
		test_led_mapping();
		test_heartbeat();

		repeat (2) @(negedge h2f_user0_clock);
		$display("done: %0d value mismatches, %0d other errors", check_errors, other_errors);
		if (check_errors == 0 && other_errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* sim.f */
+incdir+common
+incdir+tb
common/hps_reset_pkg.sv
common/board_io_pkg.sv
design/hps_reset/hps_reset_pulse.sv
design/hps_reset/hps_reset_ctrl.sv
design/board_led_ctrl.sv
design/ghrd_fabric.sv
tb/tb_ghrd_fabric.sv
